// File: verilog/ip_rx_pkg.sv
// shared types and constants for the IPv4 receive parser
// imported by the controller, the header field bank and the top level
package ip_rx_pkg;

    // stream and header field types
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] ip_len_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [4:0]  hdr_idx_t;

    // fixed header without options
    localparam int IP_HDR_BYTES = 20;
    localparam logic [3:0] IP_VERSION = 4'd4;
    localparam logic [3:0] IP_IHL = 4'd5;

    // byte offsets of the fields that are kept
    localparam hdr_idx_t HDR_OFF_VER_IHL  = 5'd0;
    localparam hdr_idx_t HDR_OFF_LENGTH   = 5'd2;
    localparam hdr_idx_t HDR_OFF_TTL      = 5'd8;
    localparam hdr_idx_t HDR_OFF_PROTOCOL = 5'd9;
    localparam hdr_idx_t HDR_OFF_SRC_IP   = 5'd12;
    localparam hdr_idx_t HDR_OFF_DST_IP   = 5'd16;

    // frame controller states
    typedef enum logic [2:0] {
        IDLE,
        READ_HEADER,
        READ_PAYLOAD,
        READ_PAYLOAD_LAST,
        WAIT_LAST
    } rx_state_t;

endpackage

// File: verilog/ip_hdr_checksum.sv
// running ones' complement sum over the IPv4 header bytes
// sum_ok reports whether the sum including the current byte is all ones
`timescale 1ns/100ps

module ip_hdr_checksum (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sum_clear,
    input  logic                hdr_store,
    input  ip_rx_pkg::hdr_idx_t hdr_idx,
    input  ip_rx_pkg::byte_t    byte_in,
    output logic                sum_ok
);

    logic [15:0] sum_q;
    logic [15:0] base;
    logic [15:0] lane;
    logic [16:0] raw;
    logic [15:0] sum_next;

    // a new frame starts from zero instead of the old sum
    assign base = sum_clear ? 16'h0000 : sum_q;

    // even bytes are the high half of a 16-bit word
    assign lane = hdr_idx[0] ? {8'h00, byte_in} : {byte_in, 8'h00};

    // end-around carry
    assign raw = base + lane;
    assign sum_next = raw[15:0] + {15'd0, raw[16]};
    assign sum_ok = (sum_next == 16'hffff);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_q <= 16'h0000;
        end else if (hdr_store) begin
            sum_q <= sum_next;
        end
    end

endmodule

// File: verilog/ip_hdr_fields.sv
// captures the kept IPv4 header fields as the header bytes stream in
// fields hold their value until the next frame overwrites them
`timescale 1ns/100ps

module ip_hdr_fields (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 hdr_store,
    input  ip_rx_pkg::hdr_idx_t  hdr_idx,
    input  ip_rx_pkg::byte_t     byte_in,
    output logic [3:0]           ip_version,
    output logic [3:0]           ip_ihl,
    output ip_rx_pkg::ip_len_t   ip_length,
    output ip_rx_pkg::byte_t     ip_ttl,
    output ip_rx_pkg::byte_t     ip_protocol,
    output ip_rx_pkg::ip_addr_t  ip_source_ip,
    output ip_rx_pkg::ip_addr_t  ip_dest_ip
);

    import ip_rx_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ip_version   <= '0;
            ip_ihl       <= '0;
            ip_length    <= '0;
            ip_ttl       <= '0;
            ip_protocol  <= '0;
            ip_source_ip <= '0;
            ip_dest_ip   <= '0;
        end else if (hdr_store) begin
            if (hdr_idx == HDR_OFF_VER_IHL) begin
                {ip_version, ip_ihl} <= byte_in;
            end
            // length arrives high byte first
            if (hdr_idx == HDR_OFF_LENGTH) begin
                ip_length[15:8] <= byte_in;
            end
            if (hdr_idx == HDR_OFF_LENGTH + 5'd1) begin
                ip_length[7:0] <= byte_in;
            end
            if (hdr_idx == HDR_OFF_TTL) begin
                ip_ttl <= byte_in;
            end
            if (hdr_idx == HDR_OFF_PROTOCOL) begin
                ip_protocol <= byte_in;
            end
            // addresses shift in msb first
            if (hdr_idx >= HDR_OFF_SRC_IP && hdr_idx < HDR_OFF_DST_IP) begin
                ip_source_ip <= {ip_source_ip[23:0], byte_in};
            end
            if (hdr_idx >= HDR_OFF_DST_IP) begin
                ip_dest_ip <= {ip_dest_ip[23:0], byte_in};
            end
        end
    end

endmodule

// File: verilog/ip_rx_ctrl.sv
// frame FSM of the IPv4 receive parser for header, payload trimming and errors
// drives the field bank and checksum, and feeds the payload skid buffer
`timescale 1ns/100ps

module ip_rx_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  ip_rx_pkg::byte_t    s_tdata,
    input  logic                s_tvalid,
    input  logic                s_tlast,
    output logic                s_tready,
    output logic                m_hdr_valid,
    input  logic                m_hdr_ready,
    output logic                hdr_store,
    output logic                sum_clear,
    output ip_rx_pkg::hdr_idx_t hdr_idx,
    input  logic                sum_ok,
    input  logic [3:0]          ip_version,
    input  logic [3:0]          ip_ihl,
    input  ip_rx_pkg::ip_len_t  ip_length,
    output ip_rx_pkg::byte_t    int_tdata,
    output logic                int_tvalid,
    output logic                int_tlast,
    output logic                int_tuser,
    input  logic                tready_early,
    output logic                error_header_early_termination,
    output logic                error_payload_early_termination,
    output logic                error_invalid_header,
    output logic                error_invalid_checksum
);

    import ip_rx_pkg::*;

    rx_state_t state, state_next;
    hdr_idx_t  idx_next;
    ip_len_t   remaining, remaining_next;
    byte_t     last_byte;
    logic      store_last;
    logic      accept;
    logic      s_tready_next;
    logic      hdr_valid_next;
    logic      hdr_term_next, pay_term_next, bad_hdr_next, bad_sum_next;

    assign accept = s_tready && s_tvalid;

    // byte 0 is taken in IDLE and the rest in READ_HEADER
    assign hdr_store = accept && (state == IDLE || state == READ_HEADER);
    assign sum_clear = (state == IDLE);

    always_comb begin
        state_next = state;
        idx_next = hdr_idx;
        remaining_next = remaining;
        store_last = 1'b0;
        s_tready_next = 1'b0;
        hdr_valid_next = m_hdr_valid && !m_hdr_ready;
        hdr_term_next = 1'b0;
        pay_term_next = 1'b0;
        bad_hdr_next = 1'b0;
        bad_sum_next = 1'b0;
        int_tdata = s_tdata;
        int_tvalid = 1'b0;
        int_tlast = s_tlast;
        int_tuser = 1'b0;

        case (state)
            IDLE, READ_HEADER: begin
                // hold off a new frame while the previous header waits
                s_tready_next = (state == IDLE) ? !hdr_valid_next : 1'b1;
                if (accept) begin
                    s_tready_next = 1'b1;
                    idx_next = hdr_idx + 5'd1;
                    state_next = READ_HEADER;
                    if (s_tlast) begin
                        hdr_term_next = 1'b1;
                        idx_next = '0;
                        s_tready_next = !hdr_valid_next;
                        state_next = IDLE;
                    end else if (hdr_idx == hdr_idx_t'(IP_HDR_BYTES - 1)) begin
                        idx_next = '0;
                        remaining_next = ip_length - ip_len_t'(IP_HDR_BYTES);
                        if (ip_version != IP_VERSION || ip_ihl != IP_IHL) begin
                            bad_hdr_next = 1'b1;
                            state_next = WAIT_LAST;
                        end else if (!sum_ok) begin
                            bad_sum_next = 1'b1;
                            state_next = WAIT_LAST;
                        end else begin
                            hdr_valid_next = 1'b1;
                            s_tready_next = tready_early;
                            state_next = READ_PAYLOAD;
                        end
                    end
                end
            end
            READ_PAYLOAD: begin
                s_tready_next = tready_early;
                if (accept) begin
                    remaining_next = remaining - 16'd1;
                    int_tvalid = 1'b1;
                    if (s_tlast) begin
                        // frame shorter than the IP length says
                        if (remaining > 16'd1) begin
                            int_tuser = 1'b1;
                            pay_term_next = 1'b1;
                        end
                        s_tready_next = !hdr_valid_next;
                        state_next = IDLE;
                    end else if (remaining == 16'd1) begin
                        // keep the final byte until tlast shows up
                        store_last = 1'b1;
                        int_tvalid = 1'b0;
                        state_next = READ_PAYLOAD_LAST;
                    end
                end
            end
            READ_PAYLOAD_LAST: begin
                // padding is dropped while the held byte waits for tlast
                s_tready_next = tready_early;
                int_tdata = last_byte;
                if (accept && s_tlast) begin
                    int_tvalid = 1'b1;
                    s_tready_next = !hdr_valid_next;
                    state_next = IDLE;
                end
            end
            WAIT_LAST: begin
                s_tready_next = 1'b1;
                if (accept && s_tlast) begin
                    s_tready_next = !hdr_valid_next;
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            hdr_idx <= '0;
            remaining <= '0;
            s_tready <= 1'b0;
            m_hdr_valid <= 1'b0;
            error_header_early_termination <= 1'b0;
            error_payload_early_termination <= 1'b0;
            error_invalid_header <= 1'b0;
            error_invalid_checksum <= 1'b0;
        end else begin
            state <= state_next;
            hdr_idx <= idx_next;
            remaining <= remaining_next;
            s_tready <= s_tready_next;
            m_hdr_valid <= hdr_valid_next;
            error_header_early_termination <= hdr_term_next;
            error_payload_early_termination <= pay_term_next;
            error_invalid_header <= bad_hdr_next;
            error_invalid_checksum <= bad_sum_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_last) begin
            last_byte <= s_tdata;
        end
    end

endmodule

// File: verilog/axis_skid_buffer.sv
// two-register output stage for a valid/ready stream with early ready
// the upstream source registers tready_early and may send one more beat
`timescale 1ns/100ps

module axis_skid_buffer #(
    parameter int DATA_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] int_tdata,
    input  logic                  int_tvalid,
    input  logic                  int_tlast,
    input  logic                  int_tuser,
    output logic                  tready_early,
    output logic [DATA_WIDTH-1:0] m_tdata,
    output logic                  m_tvalid,
    output logic                  m_tlast,
    output logic                  m_tuser,
    input  logic                  m_tready
);

    logic                  ready_q;
    logic [DATA_WIDTH-1:0] tmp_tdata;
    logic                  tmp_tvalid, tmp_tlast, tmp_tuser;
    logic                  out_valid_next, tmp_valid_next;
    logic                  load_out, load_tmp, tmp_to_out;

    // room next cycle if the sink takes a beat or both registers are empty
    assign tready_early = m_tready || (!tmp_tvalid && !m_tvalid);

    always_comb begin
        out_valid_next = m_tvalid;
        tmp_valid_next = tmp_tvalid;
        load_out = 1'b0;
        load_tmp = 1'b0;
        tmp_to_out = 1'b0;
        if (ready_q) begin
            if (m_tready || !m_tvalid) begin
                out_valid_next = int_tvalid;
                load_out = 1'b1;
            end else begin
                // beat already in flight when the sink stalled
                tmp_valid_next = int_tvalid;
                load_tmp = 1'b1;
            end
        end else if (m_tready) begin
            out_valid_next = tmp_tvalid;
            tmp_valid_next = 1'b0;
            tmp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ready_q <= 1'b0;
            m_tvalid <= 1'b0;
            tmp_tvalid <= 1'b0;
        end else begin
            ready_q <= tready_early;
            m_tvalid <= out_valid_next;
            tmp_tvalid <= tmp_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            {m_tdata, m_tlast, m_tuser} <= {int_tdata, int_tlast, int_tuser};
        end else if (tmp_to_out) begin
            {m_tdata, m_tlast, m_tuser} <= {tmp_tdata, tmp_tlast, tmp_tuser};
        end
        if (load_tmp) begin
            {tmp_tdata, tmp_tlast, tmp_tuser} <= {int_tdata, int_tlast, int_tuser};
        end
    end

endmodule

// File: verilog/ip_eth_rx.sv
// top level of the IPv4 receive parser behind an Ethernet MAC
// takes the byte stream and gives header fields, trimmed payload and error pulses
`timescale 1ns/100ps

module ip_eth_rx (
    input  logic                clk,
    input  logic                rst_n,
    input  ip_rx_pkg::byte_t    s_tdata,
    input  logic                s_tvalid,
    input  logic                s_tlast,
    output logic                s_tready,
    output logic                m_hdr_valid,
    input  logic                m_hdr_ready,
    output ip_rx_pkg::ip_len_t  ip_length,
    output ip_rx_pkg::byte_t    ip_ttl,
    output ip_rx_pkg::byte_t    ip_protocol,
    output ip_rx_pkg::ip_addr_t ip_source_ip,
    output ip_rx_pkg::ip_addr_t ip_dest_ip,
    output ip_rx_pkg::byte_t    m_tdata,
    output logic                m_tvalid,
    output logic                m_tlast,
    output logic                m_tuser,
    input  logic                m_tready,
    output logic                error_header_early_termination,
    output logic                error_payload_early_termination,
    output logic                error_invalid_header,
    output logic                error_invalid_checksum
);

    import ip_rx_pkg::*;

    logic       hdr_store;
    logic       sum_clear;
    hdr_idx_t   hdr_idx;
    logic       sum_ok;
    logic [3:0] ip_version;
    logic [3:0] ip_ihl;
    byte_t      int_tdata;
    logic       int_tvalid, int_tlast, int_tuser;
    logic       tready_early;

    ip_rx_ctrl u_ctrl (
        .clk                             (clk),
        .rst_n                           (rst_n),
        .s_tdata                         (s_tdata),
        .s_tvalid                        (s_tvalid),
        .s_tlast                         (s_tlast),
        .s_tready                        (s_tready),
        .m_hdr_valid                     (m_hdr_valid),
        .m_hdr_ready                     (m_hdr_ready),
        .hdr_store                       (hdr_store),
        .sum_clear                       (sum_clear),
        .hdr_idx                         (hdr_idx),
        .sum_ok                          (sum_ok),
        .ip_version                      (ip_version),
        .ip_ihl                          (ip_ihl),
        .ip_length                       (ip_length),
        .int_tdata                       (int_tdata),
        .int_tvalid                      (int_tvalid),
        .int_tlast                       (int_tlast),
        .int_tuser                       (int_tuser),
        .tready_early                    (tready_early),
        .error_header_early_termination  (error_header_early_termination),
        .error_payload_early_termination (error_payload_early_termination),
        .error_invalid_header            (error_invalid_header),
        .error_invalid_checksum          (error_invalid_checksum)
    );

    ip_hdr_fields u_fields (
        .clk          (clk),
        .rst_n        (rst_n),
        .hdr_store    (hdr_store),
        .hdr_idx      (hdr_idx),
        .byte_in      (s_tdata),
        .ip_version   (ip_version),
        .ip_ihl       (ip_ihl),
        .ip_length    (ip_length),
        .ip_ttl       (ip_ttl),
        .ip_protocol  (ip_protocol),
        .ip_source_ip (ip_source_ip),
        .ip_dest_ip   (ip_dest_ip)
    );

    ip_hdr_checksum u_checksum (
        .clk       (clk),
        .rst_n     (rst_n),
        .sum_clear (sum_clear),
        .hdr_store (hdr_store),
        .hdr_idx   (hdr_idx),
        .byte_in   (s_tdata),
        .sum_ok    (sum_ok)
    );

    axis_skid_buffer #(
        .DATA_WIDTH ($bits(byte_t))
    ) u_skid (
        .clk          (clk),
        .rst_n        (rst_n),
        .int_tdata    (int_tdata),
        .int_tvalid   (int_tvalid),
        .int_tlast    (int_tlast),
        .int_tuser    (int_tuser),
        .tready_early (tready_early),
        .m_tdata      (m_tdata),
        .m_tvalid     (m_tvalid),
        .m_tlast      (m_tlast),
        .m_tuser      (m_tuser),
        .m_tready     (m_tready)
    );

endmodule

// File: test/ip_rx_model.svh
// frame builder and expected-result model for the IPv4 parser testbench
// included in the testbench module and works on its frame and expected queues
`ifndef IP_RX_MODEL_SVH
`define IP_RX_MODEL_SVH

// 20-byte header with random fields and a correct or spoiled checksum
task automatic build_header(input logic [3:0] ver, input logic [3:0] ihl,
                            input logic [15:0] length, input bit spoil);
    logic [31:0] acc;
    int i;
    for (i = 0; i < 20; i++) begin
        hdr[i] = 8'(stim_rand(256));
    end
    hdr[0] = {ver, ihl};
    hdr[2] = length[15:8];
    hdr[3] = length[7:0];
    acc = 32'd0;
    // word sum with the checksum field taken as zero
    for (i = 0; i < 20; i += 2) begin
        if (i != 10) begin
            acc = acc + {16'd0, hdr[i], hdr[i + 1]};
        end
    end
    while (acc[31:16] != 16'd0) begin
        acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
    end
    {hdr[10], hdr[11]} = ~acc[15:0];
    if (spoil) begin
        hdr[10 + stim_rand(2)] ^= 8'(1 + stim_rand(255));
    end
    for (i = 0; i < 20; i++) begin
        frame_q.push_back(hdr[i]);
    end
endtask

// length, ttl, protocol, source and destination as the DUT reports them
task automatic expect_header();
    exp_hdr.push_back({hdr[2], hdr[3], hdr[8], hdr[9], hdr[12], hdr[13], hdr[14],
                       hdr[15], hdr[16], hdr[17], hdr[18], hdr[19]});
endtask

// carried payload bytes of which only the first plen come out
task automatic add_payload(input int carried, input int plen);
    byte_t b;
    logic  last;
    logic  short_frame;
    int    i;
    short_frame = (carried < plen);
    for (i = 0; i < carried; i++) begin
        b = 8'(stim_rand(256));
        frame_q.push_back(b);
        last = (i == plen - 1) || (i == carried - 1);
        if (i < plen) begin
            exp_data.push_back({last, short_frame && last, b});
        end
    end
endtask

// bytes the DUT must drop
task automatic add_padding(input int n);
    int i;
    for (i = 0; i < n; i++) begin
        frame_q.push_back(8'(stim_rand(256)));
    end
endtask

`endif

// File: test/tb_ip_eth_rx.sv
// testbench for the IPv4 receive parser with random frames and stalls on both sides
// compares against the frame model and prints one line per test and a closing summary
`timescale 1ns/100ps

module tb_ip_eth_rx;

    import ip_rx_pkg::*;

    localparam logic [31:0] SEED = 32'hff0f;
    localparam int N_GOOD = 40;
    localparam int N_ERR = 3;
    localparam int MAX_PAY = 48;
    localparam int MAX_PAD = 8;
    localparam int RESET_CYCLES = 10;
    localparam int ERR_HDR_TERM = 0;
    localparam int ERR_PAY_TERM = 1;
    localparam int ERR_BAD_HDR = 2;
    localparam int ERR_BAD_SUM = 3;
    // worst case has every frame at full length and slowed by gaps and sink stalls
    localparam int N_FRAMES = N_GOOD + 4 * N_ERR * 2;
    localparam int MAX_FRAME = 20 + MAX_PAY + MAX_PAD;
    localparam int STALL_FACTOR = 8;
    localparam int TIMEOUT_CYCLES = (N_FRAMES * MAX_FRAME + RESET_CYCLES) * STALL_FACTOR;

    logic     clk = 1'b0;
    logic     rst_n;
    byte_t    s_tdata;
    logic     s_tvalid, s_tlast, s_tready;
    logic     m_hdr_valid, m_hdr_ready;
    ip_len_t  ip_length;
    byte_t    ip_ttl, ip_protocol;
    ip_addr_t ip_source_ip, ip_dest_ip;
    byte_t    m_tdata;
    logic     m_tvalid, m_tlast, m_tuser, m_tready;
    logic     error_header_early_termination, error_payload_early_termination;
    logic     error_invalid_header, error_invalid_checksum;

    logic [31:0] stim_state = SEED;
    logic [31:0] sink_state;
    byte_t       hdr [20];
    byte_t       frame_q [$];
    logic [95:0] exp_hdr [$];
    logic [95:0] got_hdr [$];
    logic [9:0]  exp_data [$];
    logic [9:0]  got_data [$];
    int          exp_err [4] = '{0, 0, 0, 0};
    int          got_err [4] = '{0, 0, 0, 0};
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_start_errors = 0;
    int          cycles = 0;

    ip_eth_rx UUT (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned stim_rand(input int unsigned range);
        stim_state = xorshift32(stim_state);
        return stim_state % range;
    endfunction

    `include "ip_rx_model.svh"

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    function automatic int errors_due();
        return exp_err[0] + exp_err[1] + exp_err[2] + exp_err[3];
    endfunction

    function automatic int errors_seen();
        return got_err[0] + got_err[1] + got_err[2] + got_err[3];
    endfunction

    // sink side stalls from a separate random stream
    always @(posedge clk) begin
        #0.5;
        if (rst_n) begin
            sink_state = xorshift32(sink_state);
            m_tready = (sink_state[1:0] != 2'b00);
            m_hdr_ready = (sink_state[3:2] != 2'b00);
        end
    end

    // monitor
    always @(posedge clk) begin
        if (rst_n) begin
            if (m_hdr_valid && m_hdr_ready) begin
                got_hdr.push_back({ip_length, ip_ttl, ip_protocol, ip_source_ip, ip_dest_ip});
            end
            if (m_tvalid && m_tready) begin
                got_data.push_back({m_tlast, m_tuser, m_tdata});
            end
            got_err[ERR_HDR_TERM] += error_header_early_termination;
            got_err[ERR_PAY_TERM] += error_payload_early_termination;
            got_err[ERR_BAD_HDR] += error_invalid_header;
            got_err[ERR_BAD_SUM] += error_invalid_checksum;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: DUT did not finish the frames within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    // sends frame_q byte by byte with random gaps in tvalid
    task automatic drive_frame();
        int i;
        for (i = 0; i < frame_q.size(); i++) begin
            while (stim_rand(4) == 0) begin
                @(posedge clk);
                #0.5;
            end
            s_tdata = frame_q[i];
            s_tvalid = 1'b1;
            s_tlast = (i == frame_q.size() - 1);
            do @(posedge clk); while (!s_tready);
            #0.5;
            s_tvalid = 1'b0;
            s_tlast = 1'b0;
        end
    endtask

    task automatic send_good_frame();
        int plen;
        plen = 1 + stim_rand(MAX_PAY);
        frame_q.delete();
        build_header(4'd4, 4'd5, 16'(20 + plen), 1'b0);
        expect_header();
        add_payload(plen, plen);
        add_padding(stim_rand(MAX_PAD + 1));
        drive_frame();
    endtask

    task automatic send_error_frame(input int kind);
        int         plen;
        int         cut;
        logic [3:0] ver;
        logic [3:0] ihl;
        plen = 2 + stim_rand(MAX_PAY - 1);
        ver = 4'd4;
        ihl = 4'd5;
        frame_q.delete();
        case (kind)
            ERR_BAD_HDR: begin
                if (stim_rand(2) == 0) begin
                    ver = 4'(stim_rand(16));
                    if (ver == 4'd4) begin
                        ver = 4'd6;
                    end
                end else begin
                    ihl = 4'(6 + stim_rand(10));
                end
                build_header(ver, ihl, 16'(20 + plen), 1'b0);
                add_padding(plen);
            end
            ERR_BAD_SUM: begin
                build_header(ver, ihl, 16'(20 + plen), 1'b1);
                add_padding(plen);
            end
            ERR_HDR_TERM: begin
                // tlast somewhere in bytes 0 to 19
                cut = 1 + stim_rand(20);
                build_header(ver, ihl, 16'(20 + plen), 1'b0);
                while (frame_q.size() > cut) begin
                    void'(frame_q.pop_back());
                end
            end
            default: begin
                build_header(ver, ihl, 16'(20 + plen), 1'b0);
                expect_header();
                add_payload(1 + stim_rand(plen - 1), plen);
            end
        endcase
        exp_err[kind]++;
        drive_frame();
    endtask

    task automatic report_test(input string name);
        tests++;
        $display("test %-20s done, %0d mismatches", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    task automatic end_test(input string name);
        int k;
        while (got_hdr.size() < exp_hdr.size() || got_data.size() < exp_data.size()
               || errors_seen() < errors_due()) begin
            @(posedge clk);
            #0.5;
        end
        check({name, " header count"}, exp_hdr.size(), got_hdr.size());
        check({name, " byte count"}, exp_data.size(), got_data.size());
        while (exp_hdr.size() > 0 && got_hdr.size() > 0) begin
            check({name, " header"}, exp_hdr.pop_front(), got_hdr.pop_front());
        end
        while (exp_data.size() > 0 && got_data.size() > 0) begin
            check({name, " payload"}, exp_data.pop_front(), got_data.pop_front());
        end
        for (k = 0; k < 4; k++) begin
            check({name, " error pulses"}, exp_err[k], got_err[k]);
        end
        report_test(name);
    endtask

    task automatic run_error_test(input int kind, input string name);
        repeat (N_ERR) begin
            send_error_frame(kind);
            send_good_frame();
        end
        end_test(name);
    endtask

    initial begin
        int i;
        rst_n = 1'b0;
        s_tdata = '0;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        m_tready = 1'b0;
        m_hdr_ready = 1'b0;
        sink_state = SEED ^ 32'h9e3779b9;

        // first edge only settles the registers
        for (i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check("reset outputs", 7'd0, {s_tready, m_hdr_valid, m_tvalid,
                      error_header_early_termination, error_payload_early_termination,
                      error_invalid_header, error_invalid_checksum});
            end
        end
        #0.5;
        rst_n = 1'b1;
        @(posedge clk);
        check("reset outputs", 7'd0, {s_tready, m_hdr_valid, m_tvalid,
              error_header_early_termination, error_payload_early_termination,
              error_invalid_header, error_invalid_checksum});
        @(posedge clk);
        check("reset s_tready rise", 1'b1, s_tready);
        #0.5;
        report_test("reset_state");

        repeat (N_GOOD) begin
            send_good_frame();
        end
        end_test("good_frames");
        run_error_test(ERR_BAD_HDR, "invalid_header");
        run_error_test(ERR_BAD_SUM, "bad_checksum");
        run_error_test(ERR_HDR_TERM, "header_early_term");
        run_error_test(ERR_PAY_TERM, "payload_early_term");

        $display("tests: %0d, checks: %0d, mismatches: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+test
verilog/ip_rx_pkg.sv
verilog/ip_hdr_checksum.sv
verilog/ip_hdr_fields.sv
verilog/ip_rx_ctrl.sv
verilog/axis_skid_buffer.sv
verilog/ip_eth_rx.sv
test/tb_ip_eth_rx.sv

// File: Bender.yml
package:
  name: ip_eth_rx

sources:
  - files:
      - verilog/ip_rx_pkg.sv
      - verilog/ip_hdr_checksum.sv
      - verilog/ip_hdr_fields.sv
      - verilog/ip_rx_ctrl.sv
      - verilog/axis_skid_buffer.sv
      - verilog/ip_eth_rx.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_ip_eth_rx.sv
